// File: src.f
src/mips_pkg.sv
src/pipe_reg.sv
src/regfile.sv
src/alu.sv
src/control_unit.sv
src/data_path.sv
src/mips_core.sv
verif/tb_mem_model.sv
verif/tb_mips_core.sv

// File: src/alu.sv
`timescale 1ns/10ps

module alu #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0]  operand_a,
    input  logic [XLEN-1:0]  operand_b,
    input  mips_pkg::alu_op_t alu_op,
    output logic [XLEN-1:0]  result,
    output logic             zero,
    output logic             negative
);

    always_comb begin
        case (alu_op)
            mips_pkg::ALU_ADD: begin
                result = operand_a + operand_b;
            end
            mips_pkg::ALU_SUB: begin
                result = operand_a - operand_b;
            end
            mips_pkg::ALU_AND: begin
                result = operand_a & operand_b;
            end
            mips_pkg::ALU_OR: begin
                result = operand_a | operand_b;
            end
            mips_pkg::ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            end
            // Shift amount arrives on operand_a
            mips_pkg::ALU_SLL: begin
                result = operand_b << operand_a[4:0];
            end
            mips_pkg::ALU_SRL: begin
                result = operand_b >> operand_a[4:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[XLEN-1];

endmodule

// File: src/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic [31:0]       inst_id,
    output logic              reg_dest,
    output logic              reg_write,
    output logic              alu_src,
    output logic              shamt_src,
    output logic              mem_read,
    output logic              mem_write,
    output logic              mem_to_reg,
    output logic              link,
    output logic              branch,
    output logic              branch_ne,
    output logic              jump,
    output logic              jump_register,
    output logic              halt,
    output logic              is_unsigned,
    output mips_pkg::alu_op_t alu_op
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst_id[31:26];
    assign funct  = inst_id[5:0];

    always_comb begin
        {reg_dest, reg_write, alu_src, shamt_src, mem_read, mem_write, mem_to_reg,
         link, branch, branch_ne, jump, jump_register, halt, is_unsigned} = '0;
        alu_op = mips_pkg::ALU_ADD;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                {reg_dest, reg_write} = 2'b11;
                case (funct)
                    mips_pkg::FN_ADD: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: begin
                        alu_op    = mips_pkg::ALU_SLL;
                        shamt_src = 1'b1;
                    end
                    mips_pkg::FN_SRL: begin
                        alu_op    = mips_pkg::ALU_SRL;
                        shamt_src = 1'b1;
                    end
                    mips_pkg::FN_JR: begin
                        reg_write     = 1'b0;
                        jump_register = 1'b1;
                    end
                    default: reg_write = 1'b0;  // Unknown funct is a nop
                endcase
            end
            mips_pkg::OP_ADDI: {reg_write, alu_src} = 2'b11;
            mips_pkg::OP_ANDI: begin
                {reg_write, alu_src, is_unsigned} = 3'b111;
                alu_op = mips_pkg::ALU_AND;
            end
            mips_pkg::OP_ORI: begin
                {reg_write, alu_src, is_unsigned} = 3'b111;
                alu_op = mips_pkg::ALU_OR;
            end
            mips_pkg::OP_LW: {reg_write, alu_src, mem_read, mem_to_reg} = 4'b1111;
            mips_pkg::OP_SW: {alu_src, mem_write} = 2'b11;
            mips_pkg::OP_BEQ: begin
                branch = 1'b1;
                alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_BNE: begin
                {branch, branch_ne} = 2'b11;
                alu_op = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_J:    jump = 1'b1;
            mips_pkg::OP_JAL:  {jump, link, reg_write} = 3'b111;
            mips_pkg::OP_HALT: halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: src/data_path.sv
`timescale 1ns/10ps

module data_path #(
    parameter int XLEN = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [31:0]       inst,
    output logic [XLEN-1:0]   inst_addr,
    output logic [XLEN-1:0]   mem_addr,
    output logic [XLEN-1:0]   mem_wdata,
    output logic              mem_we,
    output logic              mem_re,
    input  logic [XLEN-1:0]   mem_rdata,
    output logic              halted,
    input  logic              reg_dest,
    input  logic              reg_write,
    input  logic              alu_src,
    input  logic              shamt_src,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              mem_to_reg,
    input  logic              link,
    input  logic              branch,
    input  logic              branch_ne,
    input  logic              jump,
    input  logic              jump_register,
    input  logic              halt,
    input  logic              is_unsigned,
    input  mips_pkg::alu_op_t alu_op,
    output logic [31:0]       inst_id
);

    mips_pkg::if_id_t  if_id_d, if_id_q;
    mips_pkg::id_ex_t  id_ex_d, id_ex_q;
    mips_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    mips_pkg::mem_wb_t mem_wb_d, mem_wb_q;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] rs_data_id;
    logic [XLEN-1:0] rt_data_id;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;
    logic            alu_zero;
    logic            redirect;
    logic            stall;
    logic            flush;

    // IF
    assign pc_plus4  = pc + 32'd4;
    assign inst_addr = pc;
    assign if_id_d   = {pc_plus4, inst};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    pipe_reg #(.payload_t(mips_pkg::if_id_t)) u_if_id (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush(flush), .d(if_id_d), .q(if_id_q)
    );

    // ID
    assign inst_id = if_id_q.inst;

    regfile #(.XLEN(XLEN)) u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_num  (inst_id[25:21]),
        .rt_num  (inst_id[20:16]),
        .rd_num  (mem_wb_q.dest),
        .rd_data (wb_data),
        .rd_we   (mem_wb_q.reg_write),
        .rs_data (rs_data_id),
        .rt_data (rt_data_id)
    );

    always_comb begin
        id_ex_d.reg_write     = reg_write;
        id_ex_d.mem_read      = mem_read;
        id_ex_d.mem_write     = mem_write;
        id_ex_d.mem_to_reg    = mem_to_reg;
        id_ex_d.link          = link;
        id_ex_d.alu_src       = alu_src;
        id_ex_d.shamt_src     = shamt_src;
        id_ex_d.branch        = branch;
        id_ex_d.branch_ne     = branch_ne;
        id_ex_d.jump          = jump;
        id_ex_d.jump_register = jump_register;
        id_ex_d.halt          = halt;
        id_ex_d.alu_op        = alu_op;
        id_ex_d.pc_plus4      = if_id_q.pc_plus4;
        id_ex_d.jump_target   = {if_id_q.pc_plus4[31:28], inst_id[25:0], 2'b00};
        id_ex_d.rs_data       = rs_data_id;
        id_ex_d.rt_data       = rt_data_id;
        id_ex_d.imm           = is_unsigned ? {16'b0, inst_id[15:0]}
                                            : {{16{inst_id[15]}}, inst_id[15:0]};
        id_ex_d.shamt         = inst_id[10:6];
        id_ex_d.dest          = link ? 5'd31 : (reg_dest ? inst_id[15:11] : inst_id[20:16]);
    end

    pipe_reg #(.payload_t(mips_pkg::id_ex_t)) u_id_ex (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush(flush), .d(id_ex_d), .q(id_ex_q)
    );

    // EX
    assign alu_a = id_ex_q.shamt_src ? {{(XLEN-5){1'b0}}, id_ex_q.shamt} : id_ex_q.rs_data;
    assign alu_b = id_ex_q.alu_src ? id_ex_q.imm : id_ex_q.rt_data;

    alu #(.XLEN(XLEN)) u_alu (
        .operand_a (alu_a),
        .operand_b (alu_b),
        .alu_op    (id_ex_q.alu_op),
        .result    (alu_result),
        .zero      (alu_zero),
        .negative  ()
    );

    always_comb begin
        ex_mem_d.reg_write     = id_ex_q.reg_write;
        ex_mem_d.mem_read      = id_ex_q.mem_read;
        ex_mem_d.mem_write     = id_ex_q.mem_write;
        ex_mem_d.mem_to_reg    = id_ex_q.mem_to_reg;
        ex_mem_d.link          = id_ex_q.link;
        ex_mem_d.branch        = id_ex_q.branch;
        ex_mem_d.branch_ne     = id_ex_q.branch_ne;
        ex_mem_d.jump          = id_ex_q.jump;
        ex_mem_d.jump_register = id_ex_q.jump_register;
        ex_mem_d.halt          = id_ex_q.halt;
        ex_mem_d.zero          = alu_zero;
        ex_mem_d.alu_result    = alu_result;
        ex_mem_d.rt_data       = id_ex_q.rt_data;
        ex_mem_d.branch_target = id_ex_q.pc_plus4 + {id_ex_q.imm[29:0], 2'b00};
        ex_mem_d.jump_target   = id_ex_q.jump_target;
        ex_mem_d.rs_data       = id_ex_q.rs_data;
        ex_mem_d.pc_plus4      = id_ex_q.pc_plus4;
        ex_mem_d.dest          = id_ex_q.dest;
    end

    pipe_reg #(.payload_t(mips_pkg::ex_mem_t)) u_ex_mem (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush(flush), .d(ex_mem_d), .q(ex_mem_q)
    );

    // MEM
    assign mem_addr  = ex_mem_q.alu_result;
    assign mem_wdata = ex_mem_q.rt_data;
    assign mem_we    = ex_mem_q.mem_write & ~halted;  // Store behind a halt never lands
    assign mem_re    = ex_mem_q.mem_read;

    assign redirect = (ex_mem_q.branch & (ex_mem_q.zero ^ ex_mem_q.branch_ne))
                    | ex_mem_q.jump | ex_mem_q.jump_register;
    assign flush    = redirect;
    assign stall    = halted;

    always_comb begin
        if (!redirect) begin
            pc_next = pc_plus4;
        end else if (ex_mem_q.jump_register) begin
            pc_next = ex_mem_q.rs_data;
        end else if (ex_mem_q.jump) begin
            pc_next = ex_mem_q.jump_target;
        end else begin
            pc_next = ex_mem_q.branch_target;
        end
    end

    assign mem_wb_d = '{
        reg_write:  ex_mem_q.reg_write,
        mem_to_reg: ex_mem_q.mem_to_reg,
        link:       ex_mem_q.link,
        halt:       ex_mem_q.halt,
        load_data:  mem_rdata,
        alu_result: ex_mem_q.alu_result,
        pc_plus4:   ex_mem_q.pc_plus4,
        dest:       ex_mem_q.dest
    };

    // The redirecting instruction itself must still retire
    pipe_reg #(.payload_t(mips_pkg::mem_wb_t)) u_mem_wb (
        .clk(clk), .arst_n(arst_n), .stall(stall), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    // WB
    assign wb_data = mem_wb_q.link       ? mem_wb_q.pc_plus4 :
                     mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;
    assign halted  = mem_wb_q.halt;  // Held by the stall until reset

endmodule

// File: src/mips_core.sv
`timescale 1ns/10ps

module mips_core #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            arst_n,
    output logic [XLEN-1:0] inst_addr,
    input  logic [31:0]     inst,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wdata,
    output logic            mem_we,
    output logic            mem_re,
    input  logic [XLEN-1:0] mem_rdata,
    output logic            halted
);

    logic [31:0]       inst_id;
    logic              reg_dest;
    logic              reg_write;
    logic              alu_src;
    logic              shamt_src;
    logic              mem_read;
    logic              mem_write;
    logic              mem_to_reg;
    logic              link;
    logic              branch;
    logic              branch_ne;
    logic              jump;
    logic              jump_register;
    logic              halt;
    logic              is_unsigned;
    mips_pkg::alu_op_t alu_op;

    control_unit u_control (
        .inst_id       (inst_id),
        .reg_dest      (reg_dest),
        .reg_write     (reg_write),
        .alu_src       (alu_src),
        .shamt_src     (shamt_src),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_to_reg    (mem_to_reg),
        .link          (link),
        .branch        (branch),
        .branch_ne     (branch_ne),
        .jump          (jump),
        .jump_register (jump_register),
        .halt          (halt),
        .is_unsigned   (is_unsigned),
        .alu_op        (alu_op)
    );

    data_path #(.XLEN(XLEN)) u_data_path (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst          (inst),
        .inst_addr     (inst_addr),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_we        (mem_we),
        .mem_re        (mem_re),
        .mem_rdata     (mem_rdata),
        .halted        (halted),
        .reg_dest      (reg_dest),
        .reg_write     (reg_write),
        .alu_src       (alu_src),
        .shamt_src     (shamt_src),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_to_reg    (mem_to_reg),
        .link          (link),
        .branch        (branch),
        .branch_ne     (branch_ne),
        .jump          (jump),
        .jump_register (jump_register),
        .halt          (halt),
        .is_unsigned   (is_unsigned),
        .alu_op        (alu_op),
        .inst_id       (inst_id)
    );

endmodule

// File: src/mips_pkg.sv
package mips_pkg;

    // Major opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_HALT  = 6'h3f;

    // R-type function field
    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_JR  = 6'h08;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6
    } alu_op_t;

    typedef struct packed {
        logic [31:0] pc_plus4;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        mem_to_reg;
        logic        link;
        logic        alu_src;
        logic        shamt_src;
        logic        branch;
        logic        branch_ne;
        logic        jump;
        logic        jump_register;
        logic        halt;
        alu_op_t     alu_op;
        logic [31:0] pc_plus4;
        logic [31:0] jump_target;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] imm;
        logic [4:0]  shamt;
        logic [4:0]  dest;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        mem_to_reg;
        logic        link;
        logic        branch;
        logic        branch_ne;
        logic        jump;
        logic        jump_register;
        logic        halt;
        logic        zero;
        logic [31:0] alu_result;
        logic [31:0] rt_data;
        logic [31:0] branch_target;
        logic [31:0] jump_target;
        logic [31:0] rs_data;
        logic [31:0] pc_plus4;
        logic [4:0]  dest;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_to_reg;
        logic        link;
        logic        halt;
        logic [31:0] load_data;
        logic [31:0] alu_result;
        logic [31:0] pc_plus4;
        logic [4:0]  dest;
    } mem_wb_t;

endpackage

// File: src/pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Zero payload is a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (!stall) begin
            if (flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/10ps

module regfile #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [4:0]      rs_num,
    input  logic [4:0]      rt_num,
    input  logic [4:0]      rd_num,
    input  logic [XLEN-1:0] rd_data,
    input  logic            rd_we,
    output logic [XLEN-1:0] rs_data,
    output logic [XLEN-1:0] rt_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_num != 5'd0) begin
            regs[rd_num] <= rd_data;
        end
    end

    // Same-cycle write is seen by the ID read
    assign rs_data = (rs_num == 5'd0) ? '0 :
                     (rd_we && rd_num == rs_num) ? rd_data : regs[rs_num];
    assign rt_data = (rt_num == 5'd0) ? '0 :
                     (rd_we && rd_num == rt_num) ? rd_data : regs[rt_num];

endmodule

// File: verif/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model (
    input  logic        clk,
    input  logic [31:0] inst_addr,
    output logic [31:0] inst,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic        mem_we,
    input  logic        mem_re,
    output logic [31:0] mem_rdata
);

    logic [31:0] rom [256];
    logic [31:0] ram [256];

    // Both reads answer in the same cycle
    assign inst      = rom[inst_addr[9:2]];
    assign mem_rdata = mem_re ? ram[mem_addr[9:2]] : '0;

    always @(posedge clk) begin
        if (mem_we) begin
            ram[mem_addr[9:2]] <= mem_wdata;
        end
    end

    // Unused ROM words decode as halt
    task automatic fill();
        for (int i = 0; i < 256; i++) begin
            rom[i] = {mips_pkg::OP_HALT, 18'd0, 8'(i)};
            ram[i] = {8'(i), ~8'(i), 8'(i), ~8'(i)};
        end
    endtask

endmodule

// File: verif/tb_mips_core.sv
`timescale 1ns/10ps

module tb_mips_core;

    localparam int          HALT_TIMEOUT = 2000;
    localparam int          SUB_INDEX    = 224;     // Subroutine sits past the halt
    localparam logic [31:0] OPERAND_BASE = 32'h200;
    localparam logic [31:0] SHADOW_ADDR  = 32'h300;

    logic        clk;
    logic        arst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_we;
    logic        mem_re;
    logic [31:0] mem_rdata;
    logic        halted;

    logic [63:0] exp_q[$];  // {addr, data} in program order
    logic        exp_valid;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    int          pc_words;
    int          operand_count;
    logic [31:0] result_addr;

    mips_core #(.XLEN(32)) u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_addr (inst_addr),
        .inst      (inst),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    tb_mem_model u_mem (
        .clk       (clk),
        .inst_addr (inst_addr),
        .inst      (inst),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] shamt,
                                               input logic [5:0] fn);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] op, input int index);
        return {op, 26'(index)};
    endfunction

    function automatic logic [31:0] sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic refresh_head();
        exp_valid = (exp_q.size() > 0);
        exp_addr  = '0;
        exp_data  = '0;
        if (exp_valid) begin
            exp_addr = exp_q[0][63:32];
            exp_data = exp_q[0][31:0];
        end
    endtask

    task automatic emit(input logic [31:0] word);
        u_mem.rom[pc_words] = word;
        pc_words++;
    endtask

    task automatic pad_nops(input int count);
        repeat (count) emit(32'h0);
    endtask

    task automatic load_operand(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] addr;
        addr = OPERAND_BASE + 32'(4 * operand_count);
        u_mem.ram[addr[9:2]] = value;
        operand_count++;
        emit(itype_word(mips_pkg::OP_LW, 5'd0, rd, addr[15:0]));
        pad_nops(2);
    endtask

    // Two nops clear the producer, then a store that must land
    task automatic checked_store(input logic [4:0] rt, input logic [31:0] value);
        pad_nops(2);
        emit(itype_word(mips_pkg::OP_SW, 5'd0, rt, result_addr[15:0]));
        exp_q.push_back({result_addr, value});
        result_addr += 32'd4;
    endtask

    task automatic shadow_store(input logic [4:0] rt);
        emit(itype_word(mips_pkg::OP_SW, 5'd0, rt, SHADOW_ADDR[15:0]));
    endtask

    task automatic alu_case(input logic [31:0] word, input logic [31:0] value);
        emit(word);
        checked_store(5'd3, value);
    endtask

    task automatic branch_case(input logic [5:0] op, input logic [4:0] rt, input logic taken,
                               input logic [31:0] value);
        emit(itype_word(op, 5'd1, rt, 16'd3));  // Lands just past the three slots
        if (taken) begin
            repeat (3) shadow_store(5'd1);
        end else begin
            checked_store(5'd1, value);
        end
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [15:0] imm;
        logic [15:0] imm2;
        logic [4:0]  sh;
        logic [31:0] stored_at;
        int          jal_index;
        int          resume;
        a    = $urandom();
        b    = $urandom();
        c    = $urandom();
        imm  = 16'($urandom()) | 16'h8000;  // Sign and zero extension must differ
        imm2 = 16'($urandom());
        sh   = 5'(1 + $urandom() % 31);     // Nonzero so every shift moves bits
        a[31] = 1'b0;  // Opposite signs tell signed slt and logical srl apart
        b[31] = 1'b1;
        pc_words      = 0;
        operand_count = 0;
        result_addr   = '0;
        exp_q.delete();
        u_mem.fill();

        load_operand(5'd1, a);
        load_operand(5'd2, b);
        alu_case(rtype_word(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FN_ADD), a + b);
        alu_case(rtype_word(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FN_SUB), a - b);
        alu_case(rtype_word(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FN_AND), a & b);
        alu_case(rtype_word(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FN_OR), a | b);
        alu_case(rtype_word(5'd1, 5'd2, 5'd3, 5'd0, mips_pkg::FN_SLT),
                 {31'b0, $signed(a) < $signed(b)});
        alu_case(rtype_word(5'd2, 5'd1, 5'd3, 5'd0, mips_pkg::FN_SLT),
                 {31'b0, $signed(b) < $signed(a)});
        alu_case(rtype_word(5'd0, 5'd2, 5'd3, sh, mips_pkg::FN_SLL), b << sh);
        alu_case(rtype_word(5'd0, 5'd2, 5'd3, sh, mips_pkg::FN_SRL), b >> sh);
        alu_case(itype_word(mips_pkg::OP_ADDI, 5'd1, 5'd3, imm), a + sext16(imm));
        alu_case(itype_word(mips_pkg::OP_ANDI, 5'd1, 5'd3, imm), a & {16'h0, imm});
        alu_case(itype_word(mips_pkg::OP_ORI, 5'd1, 5'd3, imm), a | {16'h0, imm});

        // Round trip through data memory
        load_operand(5'd4, c);
        stored_at = result_addr;
        checked_store(5'd4, c);
        emit(itype_word(mips_pkg::OP_LW, 5'd0, 5'd5, stored_at[15:0]));
        pad_nops(2);
        alu_case(itype_word(mips_pkg::OP_ADDI, 5'd5, 5'd3, imm2), c + sext16(imm2));

        branch_case(mips_pkg::OP_BEQ, 5'd1, 1'b1, a);
        branch_case(mips_pkg::OP_BEQ, 5'd2, 1'b0, a);
        branch_case(mips_pkg::OP_BNE, 5'd2, 1'b1, a);
        branch_case(mips_pkg::OP_BNE, 5'd1, 1'b0, a);

        emit(jump_word(mips_pkg::OP_J, pc_words + 4));
        repeat (3) shadow_store(5'd1);
        checked_store(5'd2, b);

        jal_index = pc_words;
        emit(jump_word(mips_pkg::OP_JAL, SUB_INDEX));
        resume   = pc_words;
        pc_words = SUB_INDEX;
        checked_store(5'd31, 32'(4 * (jal_index + 1)));  // Link is PC+4 of the jal
        emit(rtype_word(5'd31, 5'd0, 5'd0, 5'd0, mips_pkg::FN_JR));
        repeat (3) shadow_store(5'd1);
        pc_words = resume;
        checked_store(5'd1, a);  // Reached only through jr

        emit({mips_pkg::OP_HALT, 26'd0});
        repeat (4) shadow_store(5'd1);
        refresh_head();
    endtask

    task automatic check_idle_outputs();
        assert (!halted && !mem_we && !mem_re && inst_addr == 32'h0)
        else end_with_failure($sformatf(
            "Fail at %0t: outputs not idle around reset (halted %b we %b re %b pc %h)",
            $time, halted, mem_we, mem_re, inst_addr));
    endtask

    // Retire the expected write seen this cycle
    always @(negedge clk) begin
        if (arst_n && mem_we && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    unexpected_write: assert property (@(negedge clk) disable iff (!arst_n)
                                       mem_we |-> exp_valid)
    else end_with_failure($sformatf("Fail at %0t: unexpected store of %h to address %h",
                                    $time, $sampled(mem_wdata), $sampled(mem_addr)));

    write_address: assert property (@(negedge clk) disable iff (!arst_n)
                                    mem_we && exp_valid |-> mem_addr == exp_addr)
    else end_with_failure($sformatf("Fail at %0t: store address %h, expected %h",
                                    $time, $sampled(mem_addr), $sampled(exp_addr)));

    write_data: assert property (@(negedge clk) disable iff (!arst_n)
                                 mem_we && exp_valid |-> mem_wdata == exp_data)
    else end_with_failure($sformatf("Fail at %0t: store data %h at %h, expected %h",
                                    $time, $sampled(mem_wdata), $sampled(mem_addr),
                                    $sampled(exp_data)));

    initial begin
        int cycles;
        void'($urandom(32'h18dd_92b6));
        arst_n = 1'b0;
        build_program();
        repeat (16) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        arst_n = 1'b1;
        #5;
        check_idle_outputs();

        cycles = 0;
        while (!halted) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > HALT_TIMEOUT) begin
                end_with_failure("The core did not halt before the timeout ran out");
            end
        end

        repeat (20) begin
            @(posedge clk);
            #1;
            assert (halted)
            else end_with_failure($sformatf("Fail at %0t: halted dropped after the halt",
                                            $time));
        end

        if (exp_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            end_with_failure($sformatf("Fail at %0t: %0d expected stores never appeared",
                                       $time, exp_q.size()));
        end
    end

endmodule
